// File: project.f
verilog/simd_pkg.sv
verilog/simd_op_decode.sv
verilog/simd_lane.sv
verilog/simd_result_merge.sv
verilog/simd_alu_top.sv
tb/simd_alu_tb.sv

// File: Bender.yml
package:
  name: simd_alu

sources:
  - verilog/simd_pkg.sv
  - verilog/simd_op_decode.sv
  - verilog/simd_lane.sv
  - verilog/simd_result_merge.sv
  - verilog/simd_alu_top.sv
  - target: test
    files:
      - tb/simd_alu_tb.sv

// File: tb/simd_alu_tb.sv
// SIMD ALU testbench
`timescale 1ns/1ps

module simd_alu_tb;

  localparam int NUM_LANES = 4;
  localparam int DATA_W = NUM_LANES * simd_pkg::LANE_W;
  localparam int TIMEOUT = 50;

  logic                      clk = 1'b0;
  logic                      rst;
  logic                      req;
  logic [simd_pkg::OP_W-1:0] op;
  logic [DATA_W-1:0]         a;
  logic [DATA_W-1:0]         b;
  logic                      ack;
  logic [DATA_W-1:0]         result;
  logic                      sat;
  logic                      illegal;

  logic [DATA_W-1:0] exp_result;
  logic              exp_sat;
  logic              exp_illegal;
  logic [31:0]       seed = 32'h6208_c3c5;

  logic [4:0] legal_fn [19] = '{
    simd_pkg::op_add, simd_pkg::op_sub, simd_pkg::op_adds, simd_pkg::op_subs,
    simd_pkg::op_addu, simd_pkg::op_subu, simd_pkg::op_mins, simd_pkg::op_maxs,
    simd_pkg::op_minu, simd_pkg::op_maxu, simd_pkg::op_cmpeq, simd_pkg::op_and,
    simd_pkg::op_or, simd_pkg::op_xor, simd_pkg::op_andn, simd_pkg::op_nor,
    simd_pkg::op_xnor, simd_pkg::op_mov, simd_pkg::op_not
  };
  logic [4:0] bad_fn [4] = '{5'h0b, 5'h0f, 5'h18, 5'h1f};
  logic [DATA_W-1:0] corner [8] = '{
    64'h0, '1, 64'h7f7f_7f7f_7f7f_7f7f, 64'h8080_8080_8080_8080,
    64'h7fff_7fff_7fff_7fff, 64'h8000_8000_8000_8000,
    64'h00ff_00ff_00ff_00ff, 64'h0101_0101_0101_0101
  };

  simd_alu_top #(
    .NUM_LANES (NUM_LANES)
  ) i_simd_alu_top (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .op      (op),
    .a       (a),
    .b       (b),
    .ack     (ack),
    .result  (result),
    .sat     (sat),
    .illegal (illegal)
  );

  always #2 clk = ~clk;

  // ==================================================
  // Failure reporting
  // ==================================================
  task automatic report_mismatch(input string name, input logic [63:0] expv,
      input logic [63:0] actv);
    $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, expv, actv);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic abort_run(input string what);
    $display("%0t: %s", $time, what);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  // ==================================================
  // Random numbers and reference model
  // ==================================================
  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    hi = lcg_next();
    return {hi, lcg_next()};
  endfunction

  function automatic logic is_legal(input logic [4:0] fn);
    foreach (legal_fn[i])
      if (legal_fn[i] == fn)
        return 1'b1;
    return 1'b0;
  endfunction

  // One element of width w held in the low bits of x and y.
  function automatic logic [15:0] elem_op(input logic [4:0] fn, input int w,
      input logic [15:0] x, input logic [15:0] y, output logic clamp);
    longint ux;
    longint uy;
    longint sx;
    longint sy;
    longint t;
    longint lo;
    longint hi;
    logic [15:0] mask;
    mask = 16'((longint'(1) << w) - 1);
    ux = longint'(x & mask);
    uy = longint'(y & mask);
    sx = x[w-1] ? ux - (longint'(1) << w) : ux;
    sy = y[w-1] ? uy - (longint'(1) << w) : uy;
    lo = -(longint'(1) << 60);
    hi = longint'(1) << 60;
    case (fn)
      simd_pkg::op_add:   t = ux + uy;
      simd_pkg::op_sub:   t = ux - uy;
      simd_pkg::op_adds:  t = sx + sy;
      simd_pkg::op_subs:  t = sx - sy;
      simd_pkg::op_addu:  t = ux + uy;
      simd_pkg::op_subu:  t = ux - uy;
      simd_pkg::op_mins:  t = (sx < sy) ? ux : uy;
      simd_pkg::op_maxs:  t = (sx > sy) ? ux : uy;
      simd_pkg::op_minu:  t = (ux < uy) ? ux : uy;
      simd_pkg::op_maxu:  t = (ux > uy) ? ux : uy;
      simd_pkg::op_cmpeq: t = (ux == uy) ? -1 : 0;
      simd_pkg::op_and:   t = longint'(x & y);
      simd_pkg::op_or:    t = longint'(x | y);
      simd_pkg::op_xor:   t = longint'(x ^ y);
      simd_pkg::op_andn:  t = longint'(x & ~y);
      simd_pkg::op_nor:   t = longint'(~(x | y));
      simd_pkg::op_xnor:  t = longint'(x ~^ y);
      simd_pkg::op_mov:   t = longint'(y);
      default:            t = longint'(~y);
    endcase
    // Clamp limits for the saturating group.
    if (fn == simd_pkg::op_adds || fn == simd_pkg::op_subs) begin
      lo = -(longint'(1) << (w - 1));
      hi = (longint'(1) << (w - 1)) - 1;
    end else if (fn == simd_pkg::op_addu || fn == simd_pkg::op_subu) begin
      lo = 0;
      hi = (longint'(1) << w) - 1;
    end
    clamp = (t < lo) || (t > hi);
    if (t < lo)
      t = lo;
    else if (t > hi)
      t = hi;
    return 16'(t) & mask;
  endfunction

  function automatic void ref_model(input logic [5:0] op_v, input logic [63:0] a_v,
      input logic [63:0] b_v, output logic [63:0] res, output logic s, output logic ill);
    simd_pkg::lane_word_u ra;
    simd_pkg::lane_word_u rb;
    simd_pkg::lane_word_u rr;
    logic [15:0] e;
    logic c;
    res = '0;
    s = 1'b0;
    ill = !is_legal(op_v[4:0]);
    if (ill)
      return;
    for (int i = 0; i < NUM_LANES; i++) begin
      ra = a_v[i*simd_pkg::LANE_W +: simd_pkg::LANE_W];
      rb = b_v[i*simd_pkg::LANE_W +: simd_pkg::LANE_W];
      if (op_v[5]) begin
        rr.half = elem_op(op_v[4:0], 16, ra.half, rb.half, c);
        s = s | c;
      end else begin
        for (int k = 0; k < 2; k++) begin
          e = elem_op(op_v[4:0], 8, {8'h00, ra.bytes[k]}, {8'h00, rb.bytes[k]}, c);
          rr.bytes[k] = e[7:0];
          s = s | c;
        end
      end
      res[i*simd_pkg::LANE_W +: simd_pkg::LANE_W] = rr;
    end
  endfunction

  // ==================================================
  // Checks
  // ==================================================
  a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> !ack)
    else abort_run("ack is not low after reset");
  a_ack_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(req) |-> !ack [*3] ##1 ack)
    else abort_run("ack did not rise exactly 3 edges after req");
  a_ack_hold: assert property (@(posedge clk) disable iff (rst)
    ack && req |=> ack && $stable(result) && $stable(sat) && $stable(illegal))
    else abort_run("ack or outputs changed while req was held");
  a_ack_fall: assert property (@(posedge clk) disable iff (rst)
    $fell(req) |-> ack ##1 !ack)
    else abort_run("ack did not fall one edge after req dropped");
  a_result: assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> result == exp_result)
    else report_mismatch("result", exp_result, result);
  a_sat: assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> sat == exp_sat)
    else report_mismatch("sat", 64'(exp_sat), 64'(sat));
  a_illegal: assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> illegal == exp_illegal)
    else report_mismatch("illegal", 64'(exp_illegal), 64'(illegal));

  // One full four-phase transfer between falling edges.
  task automatic run_op(input logic [5:0] op_v, input logic [63:0] a_v, input logic [63:0] b_v);
    int n;
    ref_model(op_v, a_v, b_v, exp_result, exp_sat, exp_illegal);
    op = op_v;
    a = a_v;
    b = b_v;
    req = 1'b1;
    n = 0;
    while (!ack && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!ack)
      abort_run("timeout waiting for ack to rise");
    // Random hold time exercises back-pressure.
    repeat (lcg_next() % 3) @(negedge clk);
    req = 1'b0;
    n = 0;
    while (ack && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (ack)
      abort_run("timeout waiting for ack to fall");
  endtask

  initial begin
    logic [63:0] x;
    logic [63:0] sign_bits;
    rst = 1'b1;
    req = 1'b0;
    op = '0;
    a = '0;
    b = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    for (int i = 0; i < 19; i++) begin
      for (int k = 0; k < 2; k++) begin
        sign_bits = k ? 64'h8000_8000_8000_8000 : 64'h8080_8080_8080_8080;
        for (int j = 0; j < 8; j++) begin
          run_op({k[0], legal_fn[i]}, corner[j], corner[(j+1)%8]);
          run_op({k[0], legal_fn[i]}, corner[j], corner[(j+5)%8]);
        end
        for (int j = 0; j < 8; j++) begin
          x = rand64();
          run_op({k[0], legal_fn[i]}, x, rand64());
          // Sign-bit-only differences and equal pairs.
          run_op({k[0], legal_fn[i]}, x, x ^ sign_bits);
          run_op({k[0], legal_fn[i]}, x, x);
        end
      end
    end
    // Each unknown code is followed by a legal add.
    for (int i = 0; i < 4; i++) begin
      for (int k = 0; k < 2; k++) begin
        run_op({k[0], bad_fn[i]}, rand64(), rand64());
        run_op({k[0], simd_pkg::op_add}, rand64(), rand64());
      end
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: verilog/simd_alu_top.sv
// SIMD ALU top level
`timescale 1ns/1ps

module simd_alu_top #(
  parameter int NUM_LANES = 4
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    req,
  input  logic [simd_pkg::OP_W-1:0]               op,
  input  logic [NUM_LANES*simd_pkg::LANE_W-1:0]   a,
  input  logic [NUM_LANES*simd_pkg::LANE_W-1:0]   b,
  output logic                                    ack,
  output logic [NUM_LANES*simd_pkg::LANE_W-1:0]   result,
  output logic                                    sat,
  output logic                                    illegal
);

  localparam int DATA_W = NUM_LANES * simd_pkg::LANE_W;

  logic                issue;
  logic [DATA_W-1:0]   a_reg;
  logic [DATA_W-1:0]   b_reg;
  logic                elem16;
  logic                is_sub;
  logic                is_sat;
  logic                is_sign;
  logic                is_min;
  logic                is_max;
  logic                is_cmp;
  logic                is_logic;
  simd_pkg::logic_fn_e logic_fn;
  logic                illegal_op;
  logic                busy;
  logic [DATA_W-1:0]   lane_res;
  logic [NUM_LANES-1:0] lane_sat;
  // All lanes strobe together, lane 0 stands for them.
  logic [NUM_LANES-1:0] lane_done;

  simd_op_decode #(
    .DATA_W (DATA_W)
  ) i_op_decode (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .op         (op),
    .a          (a),
    .b          (b),
    .busy       (busy),
    .issue      (issue),
    .a_reg      (a_reg),
    .b_reg      (b_reg),
    .elem16     (elem16),
    .is_sub     (is_sub),
    .is_sat     (is_sat),
    .is_sign    (is_sign),
    .is_min     (is_min),
    .is_max     (is_max),
    .is_cmp     (is_cmp),
    .is_logic   (is_logic),
    .logic_fn   (logic_fn),
    .illegal_op (illegal_op)
  );

  // ==================================================
  // Lane slices
  // ==================================================
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    simd_lane i_lane (
      .clk        (clk),
      .rst        (rst),
      .issue      (issue),
      .a          (a_reg[i*simd_pkg::LANE_W +: simd_pkg::LANE_W]),
      .b          (b_reg[i*simd_pkg::LANE_W +: simd_pkg::LANE_W]),
      .elem16     (elem16),
      .is_sub     (is_sub),
      .is_sat     (is_sat),
      .is_sign    (is_sign),
      .is_min     (is_min),
      .is_max     (is_max),
      .is_cmp     (is_cmp),
      .is_logic   (is_logic),
      .logic_fn   (logic_fn),
      .illegal_op (illegal_op),
      .lane_res   (lane_res[i*simd_pkg::LANE_W +: simd_pkg::LANE_W]),
      .lane_sat   (lane_sat[i]),
      .done       (lane_done[i])
    );
  end

  simd_result_merge #(
    .NUM_LANES (NUM_LANES)
  ) i_result_merge (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .done       (lane_done[0]),
    .lane_res   (lane_res),
    .lane_sat   (lane_sat),
    .illegal_op (illegal_op),
    .ack        (ack),
    .result     (result),
    .sat        (sat),
    .illegal    (illegal),
    .busy       (busy)
  );

endmodule

// File: verilog/simd_result_merge.sv
// SIMD result merge and ack handshake
`timescale 1ns/1ps

module simd_result_merge #(
  parameter int NUM_LANES = 4
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    req,
  input  logic                                    done,
  input  logic [NUM_LANES*simd_pkg::LANE_W-1:0]   lane_res,
  input  logic [NUM_LANES-1:0]                    lane_sat,
  input  logic                                    illegal_op,
  output logic                                    ack,
  output logic [NUM_LANES*simd_pkg::LANE_W-1:0]   result,
  output logic                                    sat,
  output logic                                    illegal,
  output logic                                    busy
);

  // ==================================================
  // Output register and ack
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      ack     <= 1'b0;
      result  <= '0;
      sat     <= 1'b0;
      illegal <= 1'b0;
    end else if (done) begin
      ack     <= 1'b1;
      result  <= lane_res;
      sat     <= |lane_sat;
      illegal <= illegal_op;
    end else if (!req) begin
      // Four-phase return to idle.
      ack <= 1'b0;
    end
  end

  // The decoder covers the issue cycle itself.
  assign busy = done | ack;

  // Requester must hold req until ack.
  a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> $past(req));

endmodule

// File: verilog/simd_lane.sv
// SIMD 16-bit lane slice
`timescale 1ns/1ps

module simd_lane (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          issue,
  input  logic [simd_pkg::LANE_W-1:0]   a,
  input  logic [simd_pkg::LANE_W-1:0]   b,
  input  logic                          elem16,
  input  logic                          is_sub,
  input  logic                          is_sat,
  input  logic                          is_sign,
  input  logic                          is_min,
  input  logic                          is_max,
  input  logic                          is_cmp,
  input  logic                          is_logic,
  input  simd_pkg::logic_fn_e           logic_fn,
  input  logic                          illegal_op,
  output logic [simd_pkg::LANE_W-1:0]   lane_res,
  output logic                          lane_sat,
  output logic                          done
);

  simd_pkg::lane_word_u ua;
  simd_pkg::lane_word_u ub;
  simd_pkg::lane_word_u bx;
  simd_pkg::lane_word_u sum;
  simd_pkg::lane_word_u res_w;
  logic [8:0]  lo_sum;
  logic [8:0]  hi_sum;
  logic        hi_cin;
  logic [1:0]  carry;
  logic [1:0]  ovf;
  logic [1:0]  lt;
  logic [1:0]  clamp;
  logic [1:0]  eq;
  logic [15:0] logic_res;
  logic        sat_w;

  // ==================================================
  // Adder with carry break at bit 8
  // ==================================================
  assign ua = a;
  assign ub = b;
  assign bx = is_sub ? ~b : b;

  assign lo_sum = {1'b0, ua.bytes[0]} + {1'b0, bx.bytes[0]} + 9'(is_sub);
  // Byte mode restarts the chain with the subtract carry-in.
  assign hi_cin = elem16 ? lo_sum[8] : is_sub;
  assign hi_sum = {1'b0, ua.bytes[1]} + {1'b0, bx.bytes[1]} + 9'(hi_cin);
  assign sum    = {hi_sum[7:0], lo_sum[7:0]};
  assign carry  = {hi_sum[8], lo_sum[8]};

  // Flags at each byte top. Byte 1 also serves the halfword element.
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      ovf[k]   = (ua.bytes[k][7] == bx.bytes[k][7]) && (sum.bytes[k][7] != ua.bytes[k][7]);
      lt[k]    = is_sign ? (sum.bytes[k][7] ^ ovf[k]) : ~carry[k];
      // Unsigned add clamps on carry out, unsigned sub on borrow.
      clamp[k] = is_sat && (is_sign ? ovf[k] : (carry[k] ^ is_sub));
      eq[k]    = ua.bytes[k] == ub.bytes[k];
    end
  end

  always_comb begin
    case (logic_fn)
      simd_pkg::lf_and:  logic_res = a & b;
      simd_pkg::lf_or:   logic_res = a | b;
      simd_pkg::lf_xor:  logic_res = a ^ b;
      simd_pkg::lf_andn: logic_res = a & ~b;
      simd_pkg::lf_nor:  logic_res = ~(a | b);
      simd_pkg::lf_xnor: logic_res = a ~^ b;
      simd_pkg::lf_mov:  logic_res = b;
      simd_pkg::lf_not:  logic_res = ~b;
      default:           logic_res = '0;
    endcase
  end

  // ==================================================
  // Result select per element
  // ==================================================
  always_comb begin
    res_w = '0;
    sat_w = 1'b0;
    if (illegal_op) begin
      res_w = '0;
    end else if (is_logic) begin
      res_w = logic_res;
    end else if (elem16) begin
      sat_w = clamp[1];
      if (is_cmp)
        res_w.half = {16{eq[0] & eq[1]}};
      else if (is_min)
        res_w.half = lt[1] ? ua.half : ub.half;
      else if (is_max)
        res_w.half = lt[1] ? ub.half : ua.half;
      else if (clamp[1] && is_sign)
        res_w.half = {ua.half[15], {15{~ua.half[15]}}};
      else if (clamp[1])
        res_w.half = {16{~is_sub}};
      else
        res_w.half = sum.half;
    end else begin
      sat_w = |clamp;
      for (int k = 0; k < 2; k++) begin
        if (is_cmp)
          res_w.bytes[k] = {8{eq[k]}};
        else if (is_min)
          res_w.bytes[k] = lt[k] ? ua.bytes[k] : ub.bytes[k];
        else if (is_max)
          res_w.bytes[k] = lt[k] ? ub.bytes[k] : ua.bytes[k];
        else if (clamp[k] && is_sign)
          res_w.bytes[k] = {ua.bytes[k][7], {7{~ua.bytes[k][7]}}};
        else if (clamp[k])
          res_w.bytes[k] = {8{~is_sub}};
        else
          res_w.bytes[k] = sum.bytes[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      done     <= 1'b0;
      lane_sat <= 1'b0;
    end else begin
      done <= issue;
      if (issue)
        lane_sat <= sat_w;
    end
  end

  always_ff @(posedge clk) begin
    if (issue)
      lane_res <= res_w;
  end

  // The decoder must never select both min and max.
  a_min_max_excl: assert property (@(posedge clk) disable iff (rst)
    issue |-> !(is_min && is_max));

endmodule

// File: verilog/simd_op_decode.sv
// SIMD request capture and decode
`timescale 1ns/1ps

module simd_op_decode #(
  parameter int DATA_W = 64
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        req,
  input  logic [simd_pkg::OP_W-1:0]   op,
  input  logic [DATA_W-1:0]           a,
  input  logic [DATA_W-1:0]           b,
  input  logic                        busy,
  output logic                        issue,
  output logic [DATA_W-1:0]           a_reg,
  output logic [DATA_W-1:0]           b_reg,
  output logic                        elem16,
  output logic                        is_sub,
  output logic                        is_sat,
  output logic                        is_sign,
  output logic                        is_min,
  output logic                        is_max,
  output logic                        is_cmp,
  output logic                        is_logic,
  output simd_pkg::logic_fn_e         logic_fn,
  output logic                        illegal_op
);

  logic start;
  logic n_known;
  logic n_sub;
  logic n_sat;
  logic n_sign;
  logic n_min;
  logic n_max;
  logic n_cmp;
  logic n_logic;
  simd_pkg::logic_fn_e n_fn;

  // Accept only when the merger is idle and nothing is in flight.
  assign start = req && !busy && !issue;

  // ==================================================
  // Function decode
  // ==================================================
  always_comb begin
    n_known = 1'b1;
    n_sub   = 1'b0;
    n_sat   = 1'b0;
    n_sign  = 1'b0;
    n_min   = 1'b0;
    n_max   = 1'b0;
    n_cmp   = 1'b0;
    n_logic = 1'b0;
    n_fn    = simd_pkg::lf_mov;
    case (op[4:0])
      simd_pkg::op_add:   n_known = 1'b1;
      simd_pkg::op_sub:   n_sub = 1'b1;
      simd_pkg::op_adds:  {n_sat, n_sign} = 2'b11;
      simd_pkg::op_subs:  {n_sub, n_sat, n_sign} = 3'b111;
      simd_pkg::op_addu:  n_sat = 1'b1;
      simd_pkg::op_subu:  {n_sub, n_sat} = 2'b11;
      // Min and max compare through the subtractor.
      simd_pkg::op_mins:  {n_sub, n_sign, n_min} = 3'b111;
      simd_pkg::op_maxs:  {n_sub, n_sign, n_max} = 3'b111;
      simd_pkg::op_minu:  {n_sub, n_min} = 2'b11;
      simd_pkg::op_maxu:  {n_sub, n_max} = 2'b11;
      simd_pkg::op_cmpeq: n_cmp = 1'b1;
      simd_pkg::op_and:   {n_logic, n_fn} = {1'b1, simd_pkg::lf_and};
      simd_pkg::op_or:    {n_logic, n_fn} = {1'b1, simd_pkg::lf_or};
      simd_pkg::op_xor:   {n_logic, n_fn} = {1'b1, simd_pkg::lf_xor};
      simd_pkg::op_andn:  {n_logic, n_fn} = {1'b1, simd_pkg::lf_andn};
      simd_pkg::op_nor:   {n_logic, n_fn} = {1'b1, simd_pkg::lf_nor};
      simd_pkg::op_xnor:  {n_logic, n_fn} = {1'b1, simd_pkg::lf_xnor};
      simd_pkg::op_mov:   {n_logic, n_fn} = {1'b1, simd_pkg::lf_mov};
      simd_pkg::op_not:   {n_logic, n_fn} = {1'b1, simd_pkg::lf_not};
      default:            n_known = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      issue      <= 1'b0;
      elem16     <= 1'b0;
      is_sub     <= 1'b0;
      is_sat     <= 1'b0;
      is_sign    <= 1'b0;
      is_min     <= 1'b0;
      is_max     <= 1'b0;
      is_cmp     <= 1'b0;
      is_logic   <= 1'b0;
      logic_fn   <= simd_pkg::lf_and;
      illegal_op <= 1'b0;
    end else begin
      issue <= start;
      if (start) begin
        elem16     <= op[5];
        is_sub     <= n_sub;
        is_sat     <= n_sat;
        is_sign    <= n_sign;
        is_min     <= n_min;
        is_max     <= n_max;
        is_cmp     <= n_cmp;
        is_logic   <= n_logic;
        logic_fn   <= n_fn;
        illegal_op <= !n_known;
      end
    end
  end

  // Operand words.
  always_ff @(posedge clk) begin
    if (start) begin
      a_reg <= a;
      b_reg <= b;
    end
  end

  // Busy from the merger must separate two issues.
  a_issue_spaced: assert property (@(posedge clk) disable iff (rst)
    issue |=> !issue until busy);

endmodule

// File: verilog/simd_pkg.sv
// SIMD ALU shared definitions
package simd_pkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int LANE_W = 16;
  // Bit 5 selects 16-bit elements, bits 4:0 hold the function.
  localparam int OP_W = 6;

  // ==================================================
  // Function codes
  // ==================================================
  localparam logic [4:0] op_add   = 5'h00;
  localparam logic [4:0] op_sub   = 5'h01;
  localparam logic [4:0] op_adds  = 5'h02;
  localparam logic [4:0] op_subs  = 5'h03;
  localparam logic [4:0] op_addu  = 5'h04;
  localparam logic [4:0] op_subu  = 5'h05;
  localparam logic [4:0] op_mins  = 5'h06;
  localparam logic [4:0] op_maxs  = 5'h07;
  localparam logic [4:0] op_minu  = 5'h08;
  localparam logic [4:0] op_maxu  = 5'h09;
  localparam logic [4:0] op_cmpeq = 5'h0a;
  // Bitwise group.
  localparam logic [4:0] op_and   = 5'h10;
  localparam logic [4:0] op_or    = 5'h11;
  localparam logic [4:0] op_xor   = 5'h12;
  localparam logic [4:0] op_andn  = 5'h13;
  localparam logic [4:0] op_nor   = 5'h14;
  localparam logic [4:0] op_xnor  = 5'h15;
  localparam logic [4:0] op_mov   = 5'h16;
  localparam logic [4:0] op_not   = 5'h17;

  // Bitwise function selector for the lanes.
  typedef enum logic [2:0] {
    lf_and,
    lf_or,
    lf_xor,
    lf_andn,
    lf_nor,
    lf_xnor,
    lf_mov,
    lf_not
  } logic_fn_e;

  // One lane word, read as two bytes or as one halfword.
  typedef union packed {
    logic [1:0][7:0] bytes;
    logic [15:0]     half;
  } lane_word_u;

endpackage
